// File: bench/pipeCases.txt
# srcA srcB dest dflg(rw,mtr,swi,und) rfA rfB alu res br target ctl(dS,iS,mul,uop,ldm) exc(pa,da,irq,fiq,und,swi)
# expected: pcF savedPC srcValA srcValB stall(F,D,E,M,W) flush(D,E,W) misc(stallUop,incE)
0 0 0 0 100 200 300 400 0 0 00 00 0 0 0 0 00 0 0
2 3 1 8 101 201 301 401 0 0 00 00 4 0 100 200 00 0 0
5 6 4 8 102 202 302 402 0 0 00 00 8 0 101 201 00 0 0
1 9 7 8 103 203 303 403 0 0 00 00 c 0 102 202 00 0 0
1 4 8 8 104 204 304 404 0 0 00 00 10 0 404 203 00 0 0
8 7 8 8 105 205 305 405 0 0 00 00 14 0 104 405 00 0 0
8 3 9 8 106 206 306 406 0 0 00 00 18 0 306 406 00 0 0
9 0 a c 107 207 307 407 0 0 00 00 1c 0 307 206 00 0 0
a 0 b 8 108 208 308 408 0 0 00 00 20 0 308 207 18 2 2
a 0 b 8 109 209 309 409 0 0 00 00 20 0 0 0 00 0 0
0 0 0 0 10a 20a 30a 40a 0 0 00 00 24 0 40a 209 00 0 0
0 0 0 0 10b 20b 30b 40b 1 80 00 00 28 0 10a 20a 00 6 0
0 0 0 0 10c 20c 30c 40c 0 0 00 00 80 0 0 0 00 0 0
0 0 0 0 10d 20d 30d 40d 0 0 10 00 84 0 10c 20c 1f 1 2
0 0 0 0 10e 20e 30e 40e 0 0 10 00 84 0 10c 20c 1f 1 2
0 0 0 0 10f 20f 30f 40f 0 0 00 00 84 0 10c 20c 00 0 0
0 0 0 2 110 210 310 410 0 0 00 00 88 0 10f 20f 10 0 0
0 0 0 0 111 211 311 411 0 0 00 01 88 0 110 210 18 4 0
0 0 0 0 112 212 312 412 0 0 00 00 88 88 111 211 10 6 0
0 0 0 0 113 213 313 413 0 0 00 00 88 88 0 0 00 4 0
0 0 0 0 114 214 314 414 0 0 00 00 8c 88 113 213 00 0 0
0 0 0 0 115 215 315 415 0 0 00 38 90 88 114 214 00 0 0
0 0 0 0 116 216 316 416 0 0 00 1f c 88 115 215 00 0 0
0 0 0 0 117 217 317 417 0 0 00 0c 10 88 116 216 00 0 0
0 0 0 0 118 218 318 418 0 0 00 06 18 88 117 217 00 0 0
0 0 0 0 119 219 319 419 0 0 00 03 1c 88 118 218 00 0 0
0 0 0 0 11a 21a 31a 41a 0 0 00 01 4 88 119 219 00 0 0
0 0 0 0 11b 21b 31b 41b 0 0 00 00 8 88 11a 21a 00 0 0
0 0 0 2 11c 21c 31c 41c 0 0 00 00 c 88 11b 21b 10 0 0
0 0 0 0 11d 21d 31d 41d 0 0 00 03 c 88 11c 21c 18 4 0
0 0 0 0 11e 21e 31e 41e 0 0 00 00 c 8 11d 21d 10 6 0
0 0 0 0 11f 21f 31f 41f 0 0 00 00 c 8 0 0 00 4 0
0 0 0 0 120 220 320 420 0 0 00 00 10 8 11f 21f 00 0 0
1 2 f 8 121 221 321 421 0 0 00 00 14 8 120 220 10 4 0
f f 3 8 122 222 322 422 0 0 00 00 14 8 121 221 10 4 0
0 0 0 0 123 223 323 423 0 0 00 00 14 8 122 222 10 4 0
0 0 0 0 124 224 324 424 0 0 00 00 14 8 123 223 00 4 0
0 0 0 0 125 225 325 425 0 0 00 00 18 8 124 224 00 0 0
0 0 0 0 126 226 326 426 0 0 05 00 1c 8 326 225 18 0 3
0 0 0 0 127 227 327 427 0 0 08 00 1c 8 126 226 1f 5 2
0 0 0 0 128 228 328 428 0 0 00 00 1c 8 126 226 00 0 0

// File: files.f
rtl/pipePkg.sv
rtl/excPkg.sv
rtl/hazard.sv
rtl/stageTags.sv
rtl/regMatch.sv
rtl/operandStage.sv
rtl/pcUnit.sv
rtl/pipeCtrl.sv
bench/pipeCtrlTb.sv

// File: bench/pipeCtrlTb.sv
`timescale 1ns/1ps

module pipeCtrlTb;
  import pipePkg::*;

  localparam int MaxCases = 64;
  localparam int ResetCycles = 16;
  // Fields per case line
  localparam int NumFields = 19;

  logic clk;
  logic rstN;
  logic [RegIdxW-1:0] srcAD, srcBD, destD;
  logic regWriteD, memToRegD, swiD, undefD;
  logic [DataW-1:0] rfAD, rfBD, aluResultM, resultW, branchTargetE;
  logic branchTakenE, dStall, iStall, multStallD, uOpStallD, ldmStmForwardE;
  logic prefetchAbort, dataAbort, irq, fiq, undefInstr, swi;
  logic [DataW-1:0] pcF, savedPC, srcValAE, srcValBE;
  logic stallF, stallD, stallE, stallM, stallW;
  logic flushD, flushE, flushW, stallUop, incrementE;

  // Stimulus and expected values, one row per cycle
  logic [31:0] cases [MaxCases][NumFields];
  int numCases = 0;
  int errors = 0;
  int checks = 0;
  logic loadDone = 1'b0;

  pipeCtrl i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic loadCases();
    int fd;
    int got;
    string text;
    fd = $fopen("bench/pipeCases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file bench/pipeCases.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && numCases < MaxCases) begin
      text = "";
      got = $fgets(text, fd);
      // Blank lines and comment lines carry no case
      if (got <= 0 || text.len() < 2 || text.substr(0, 0) == "#") continue;
      got = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        cases[numCases][0], cases[numCases][1], cases[numCases][2], cases[numCases][3],
        cases[numCases][4], cases[numCases][5], cases[numCases][6], cases[numCases][7],
        cases[numCases][8], cases[numCases][9], cases[numCases][10], cases[numCases][11],
        cases[numCases][12], cases[numCases][13], cases[numCases][14],
        cases[numCases][15], cases[numCases][16], cases[numCases][17],
        cases[numCases][18]);
      if (got != NumFields) begin
        $display("Case line %0d is short, only %0d fields could be read", numCases, got);
        errors++;
      end else begin
        numCases++;
      end
    end
    $fclose(fd);
    if (numCases == 0) begin
      $display("The case file holds no usable case lines");
      errors++;
    end
  endtask

  task automatic applyCase(int idx);
    srcAD = cases[idx][0][3:0];
    srcBD = cases[idx][1][3:0];
    destD = cases[idx][2][3:0];
    {regWriteD, memToRegD, swiD, undefD} = cases[idx][3][3:0];
    rfAD = cases[idx][4];
    rfBD = cases[idx][5];
    aluResultM = cases[idx][6];
    resultW = cases[idx][7];
    branchTakenE = cases[idx][8][0];
    branchTargetE = cases[idx][9];
    {dStall, iStall, multStallD, uOpStallD, ldmStmForwardE} = cases[idx][10][4:0];
    {prefetchAbort, dataAbort, irq, fiq, undefInstr, swi} = cases[idx][11][5:0];
  endtask

  task automatic checkField(string name, logic [31:0] got, logic [31:0] exp, int idx);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s at case %0d: got %h, expected %h", name, idx, got, exp);
      errors++;
    end
  endtask

  task automatic checkCase(int idx);
    checkField("pcF", pcF, cases[idx][12], idx);
    checkField("savedPC", savedPC, cases[idx][13], idx);
    checkField("srcValAE", srcValAE, cases[idx][14], idx);
    checkField("srcValBE", srcValBE, cases[idx][15], idx);
    checkField("stallFDEMW", {27'd0, stallF, stallD, stallE, stallM, stallW},
               cases[idx][16], idx);
    checkField("flushDEW", {29'd0, flushD, flushE, flushW}, cases[idx][17], idx);
    checkField("stallUopIncE", {30'd0, stallUop, incrementE}, cases[idx][18], idx);
  endtask

  // Watchdog sized from the case count once the file is read
  initial begin
    wait (loadDone);
    #((numCases + ResetCycles + 10) * 20);
    $display("Watchdog expired before the case list finished");
    $display("tests failed");
    $finish;
  end

  initial begin
    rstN = 1'b0;
    {srcAD, srcBD, destD, regWriteD, memToRegD, swiD, undefD} = '0;
    {rfAD, rfBD, aluResultM, resultW, branchTargetE} = '0;
    {branchTakenE, dStall, iStall, multStallD, uOpStallD, ldmStmForwardE} = '0;
    {prefetchAbort, dataAbort, irq, fiq, undefInstr, swi} = '0;
    loadCases();
    loadDone = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #2;
    rstN = 1'b1;
    // Inputs settle 2 ns after the edge, outputs sampled 2 ns before the next
    for (int i = 0; i < numCases; i++) begin
      applyCase(i);
      #16;
      checkCase(i);
      @(posedge clk);
      #2;
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: rtl/pipeCtrl.sv
`timescale 1ns/1ps

module pipeCtrl (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic [pipePkg::RegIdxW-1:0] srcAD,
  input  logic [pipePkg::RegIdxW-1:0] srcBD,
  input  logic [pipePkg::RegIdxW-1:0] destD,
  input  logic                        regWriteD,
  input  logic                        memToRegD,
  input  logic                        swiD,
  input  logic                        undefD,
  input  logic [pipePkg::DataW-1:0]   rfAD,
  input  logic [pipePkg::DataW-1:0]   rfBD,
  input  logic [pipePkg::DataW-1:0]   aluResultM,
  input  logic [pipePkg::DataW-1:0]   resultW,
  input  logic                        branchTakenE,
  input  logic [pipePkg::DataW-1:0]   branchTargetE,
  input  logic                        dStall,
  input  logic                        iStall,
  input  logic                        multStallD,
  input  logic                        uOpStallD,
  input  logic                        ldmStmForwardE,
  input  logic                        prefetchAbort,
  input  logic                        dataAbort,
  input  logic                        irq,
  input  logic                        fiq,
  input  logic                        undefInstr,
  input  logic                        swi,
  output logic [pipePkg::DataW-1:0]   pcF,
  output logic [pipePkg::DataW-1:0]   savedPC,
  output logic [pipePkg::DataW-1:0]   srcValAE,
  output logic [pipePkg::DataW-1:0]   srcValBE,
  output logic                        stallF,
  output logic                        stallD,
  output logic                        stallE,
  output logic                        stallM,
  output logic                        stallW,
  output logic                        flushD,
  output logic                        flushE,
  output logic                        flushW,
  output logic                        stallUop,
  output logic                        incrementE
);
  import pipePkg::*;
  import excPkg::*;

  // Stage tags
  logic [RegIdxW-1:0] srcAE, srcBE, destE, destM, destW;
  logic regWriteM, regWriteW, memToRegE;
  logic swiE, swiM, swiW, undefE, undefM, undefW;
  logic pcWrPendingF, pcSrcW;
  // RAW matches
  logic match1EM, match1EW, match2EM, match2EW, match1DE, match2DE;
  // Hazard decisions
  logic [1:0] forwardAE, forwardBE, pcInSelect;
  logic exceptionSavePC;
  excCause_t excCause;

  stageTags i_stageTags (
    .clk, .rstN, .srcAD, .srcBD, .destD, .regWriteD, .memToRegD, .swiD, .undefD,
    .stallD, .stallE, .stallM, .stallW, .flushD, .flushE, .flushW,
    .srcAE, .srcBE, .destE, .destM, .destW, .regWriteM, .regWriteW, .memToRegE,
    .swiE, .swiM, .swiW, .undefE, .undefM, .undefW, .pcWrPendingF, .pcSrcW
  );

  regMatch i_regMatch (
    .srcAD, .srcBD, .srcAE, .srcBE, .destE, .destM, .destW,
    .match1EM, .match1EW, .match2EM, .match2EW, .match1DE, .match2DE
  );

  hazard i_hazard (
    .match1EM, .match1EW, .match2EM, .match2EW, .match1DE, .match2DE,
    .regWriteM, .regWriteW, .branchTakenE, .memToRegE, .pcWrPendingF, .pcSrcW,
    .dStall, .iStall, .multStallD, .uOpStallD, .ldmStmForwardE,
    .prefetchAbort, .dataAbort, .irq, .fiq, .undefInstr, .swi,
    .undefD, .undefE, .undefM, .undefW, .swiD, .swiE, .swiM, .swiW,
    .forwardAE, .forwardBE, .stallF, .stallD, .stallE, .stallM, .stallW,
    .flushD, .flushE, .flushW, .incrementE, .stallUop, .exceptionSavePC,
    .pcInSelect, .excCause
  );

  operandStage i_operandStage (
    .clk, .rstN, .rfAD, .rfBD, .aluResultM, .resultW, .stallE, .flushE,
    .forwardAE, .forwardBE, .srcValAE, .srcValBE
  );

  pcUnit i_pcUnit (
    .clk, .rstN, .stallF, .branchTakenE, .exceptionSavePC, .branchTargetE,
    .pcInSelect, .excCause, .pcF, .savedPC
  );

endmodule

// File: rtl/pcUnit.sv
`timescale 1ns/1ps

module pcUnit (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      stallF,
  input  logic                      branchTakenE,
  input  logic                      exceptionSavePC,
  input  logic [pipePkg::DataW-1:0] branchTargetE,
  input  logic [1:0]                pcInSelect,
  input  excPkg::excCause_t         excCause,
  output logic [pipePkg::DataW-1:0] pcF,
  output logic [pipePkg::DataW-1:0] savedPC
);
  import pipePkg::*;
  import excPkg::*;

  logic [DataW-1:0] pcNext;
  // Amount removed from pcF to get the return address
  logic [DataW-1:0] retOffset;

  // Branch redirect beats exception entry, else sequential
  always_comb begin
    if (branchTakenE) begin
      pcNext = branchTargetE;
    end else if (excCause != excNone) begin
      pcNext = vectorAddr[excCause];
    end else begin
      pcNext = pcF + 32'd4;
    end
  end

  always_comb begin
    case (pcInSelect)
      PcInPlus4: retOffset = 32'd4;
      PcInPlus0: retOffset = 32'd0;
      default:   retOffset = 32'd8;
    endcase
  end

  // Fetch PC
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcF <= '0;
    end else if (!stallF) begin
      pcF <= pcNext;
    end
  end

  // Return PC captured on the save pulse
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      savedPC <= '0;
    end else if (exceptionSavePC) begin
      savedPC <= pcF - retOffset;
    end
  end

endmodule

// File: rtl/operandStage.sv
`timescale 1ns/1ps

module operandStage (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic [pipePkg::DataW-1:0] rfAD,
  input  logic [pipePkg::DataW-1:0] rfBD,
  input  logic [pipePkg::DataW-1:0] aluResultM,
  input  logic [pipePkg::DataW-1:0] resultW,
  input  logic                     stallE,
  input  logic                     flushE,
  input  logic [1:0]               forwardAE,
  input  logic [1:0]               forwardBE,
  output logic [pipePkg::DataW-1:0] srcValAE,
  output logic [pipePkg::DataW-1:0] srcValBE
);
  import pipePkg::*;

  // Register file values carried into execute
  logic [DataW-1:0] rfAE;
  logic [DataW-1:0] rfBE;

  // Three-way operand choice
  function automatic logic [DataW-1:0] pickOperand(
    input logic [1:0]       sel,
    input logic [DataW-1:0] regVal,
    input logic [DataW-1:0] memVal,
    input logic [DataW-1:0] wbVal
  );
    logic [DataW-1:0] val;
    case (sel)
      FwdM:    val = memVal;
      FwdW:    val = wbVal;
      FwdNone: val = regVal;
      default: val = regVal;
    endcase
    return val;
  endfunction

  // Decode to execute operand register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rfAE <= '0;
      rfBE <= '0;
    end else if (flushE) begin
      rfAE <= '0;
      rfBE <= '0;
    end else if (!stallE) begin
      rfAE <= rfAD;
      rfBE <= rfBD;
    end
  end

  assign srcValAE = pickOperand(forwardAE, rfAE, aluResultM, resultW);
  assign srcValBE = pickOperand(forwardBE, rfBE, aluResultM, resultW);

endmodule

// File: rtl/regMatch.sv
`timescale 1ns/1ps

module regMatch (
  input  logic [pipePkg::RegIdxW-1:0] srcAD,
  input  logic [pipePkg::RegIdxW-1:0] srcBD,
  input  logic [pipePkg::RegIdxW-1:0] srcAE,
  input  logic [pipePkg::RegIdxW-1:0] srcBE,
  input  logic [pipePkg::RegIdxW-1:0] destE,
  input  logic [pipePkg::RegIdxW-1:0] destM,
  input  logic [pipePkg::RegIdxW-1:0] destW,
  output logic                        match1EM,
  output logic                        match1EW,
  output logic                        match2EM,
  output logic                        match2EW,
  output logic                        match1DE,
  output logic                        match2DE
);
  import pipePkg::*;

  // Destinations that may be forwarded or stalled on
  // An r15 write is handled by the flush path
  logic okE;
  logic okM;
  logic okW;

  assign okE = destE != PcReg;
  assign okM = destM != PcReg;
  assign okW = destW != PcReg;

  // Execute sources against memory and writeback
  assign match1EM = okM & (srcAE == destM);
  assign match1EW = okW & (srcAE == destW);
  assign match2EM = okM & (srcBE == destM);
  assign match2EW = okW & (srcBE == destW);

  // Decode sources against execute, for load use
  assign match1DE = okE & (srcAD == destE);
  assign match2DE = okE & (srcBD == destE);

endmodule

// File: rtl/stageTags.sv
`timescale 1ns/1ps

module stageTags (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic [pipePkg::RegIdxW-1:0] srcAD,
  input  logic [pipePkg::RegIdxW-1:0] srcBD,
  input  logic [pipePkg::RegIdxW-1:0] destD,
  input  logic                        regWriteD,
  input  logic                        memToRegD,
  input  logic                        swiD,
  input  logic                        undefD,
  input  logic                        stallD,
  input  logic                        stallE,
  input  logic                        stallM,
  input  logic                        stallW,
  input  logic                        flushD,
  input  logic                        flushE,
  input  logic                        flushW,
  output logic [pipePkg::RegIdxW-1:0] srcAE,
  output logic [pipePkg::RegIdxW-1:0] srcBE,
  output logic [pipePkg::RegIdxW-1:0] destE,
  output logic [pipePkg::RegIdxW-1:0] destM,
  output logic [pipePkg::RegIdxW-1:0] destW,
  output logic                        regWriteM,
  output logic                        regWriteW,
  output logic                        memToRegE,
  output logic                        swiE,
  output logic                        swiM,
  output logic                        swiW,
  output logic                        undefE,
  output logic                        undefM,
  output logic                        undefW,
  output logic                        pcWrPendingF,
  output logic                        pcSrcW
);
  import pipePkg::*;

  // Decode slot holds a live instruction
  logic dValid;
  // Decode fields with a squashed slot turned into a bubble
  logic [RegIdxW-1:0] srcAV;
  logic [RegIdxW-1:0] srcBV;
  logic [RegIdxW-1:0] destV;
  logic regWriteV;
  logic memToRegV;
  logic swiV;
  logic undefV;
  logic regWriteE;

  // Decode stage is cleared the cycle after a flush
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dValid <= 1'b0;
    end else if (flushD) begin
      dValid <= 1'b0;
    end else if (!stallD) begin
      dValid <= 1'b1;
    end
  end

  assign srcAV = dValid ? srcAD : '0;
  assign srcBV = dValid ? srcBD : '0;
  assign destV = dValid ? destD : '0;
  assign regWriteV = dValid & regWriteD;
  assign memToRegV = dValid & memToRegD;
  assign swiV = dValid & swiD;
  assign undefV = dValid & undefD;

  // Execute stage
  // Flush loads a bubble ahead of any stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {srcAE, srcBE, destE, regWriteE, memToRegE, swiE, undefE} <= '0;
    end else if (flushE) begin
      {srcAE, srcBE, destE, regWriteE, memToRegE, swiE, undefE} <= '0;
    end else if (!stallE) begin
      {srcAE, srcBE, destE} <= {srcAV, srcBV, destV};
      {regWriteE, memToRegE, swiE, undefE} <= {regWriteV, memToRegV, swiV, undefV};
    end
  end

  // Memory stage has no flush source
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {destM, regWriteM, swiM, undefM} <= '0;
    end else if (!stallM) begin
      {destM, regWriteM, swiM, undefM} <= {destE, regWriteE, swiE, undefE};
    end
  end

  // Writeback stage where flush beats stall under back-pressure
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {destW, regWriteW, swiW, undefW} <= '0;
    end else if (flushW) begin
      {destW, regWriteW, swiW, undefW} <= '0;
    end else if (!stallW) begin
      {destW, regWriteW, swiW, undefW} <= {destM, regWriteM, swiM, undefM};
    end
  end

  // r15 write still in flight ahead of writeback
  assign pcWrPendingF = (regWriteV & (destV == PcReg))
                      | (regWriteE & (destE == PcReg))
                      | (regWriteM & (destM == PcReg));
  // r15 written this cycle
  assign pcSrcW = regWriteW & (destW == PcReg);

endmodule

// File: rtl/hazard.sv
`timescale 1ns/1ps

module hazard (
  input  logic              match1EM,
  input  logic              match1EW,
  input  logic              match2EM,
  input  logic              match2EW,
  input  logic              match1DE,
  input  logic              match2DE,
  input  logic              regWriteM,
  input  logic              regWriteW,
  input  logic              branchTakenE,
  input  logic              memToRegE,
  input  logic              pcWrPendingF,
  input  logic              pcSrcW,
  input  logic              dStall,
  input  logic              iStall,
  input  logic              multStallD,
  input  logic              uOpStallD,
  input  logic              ldmStmForwardE,
  input  logic              prefetchAbort,
  input  logic              dataAbort,
  input  logic              irq,
  input  logic              fiq,
  input  logic              undefInstr,
  input  logic              swi,
  input  logic              undefD,
  input  logic              undefE,
  input  logic              undefM,
  input  logic              undefW,
  input  logic              swiD,
  input  logic              swiE,
  input  logic              swiM,
  input  logic              swiW,
  output logic [1:0]        forwardAE,
  output logic [1:0]        forwardBE,
  output logic              stallF,
  output logic              stallD,
  output logic              stallE,
  output logic              stallM,
  output logic              stallW,
  output logic              flushD,
  output logic              flushE,
  output logic              flushW,
  output logic              incrementE,
  output logic              stallUop,
  output logic              exceptionSavePC,
  output logic [1:0]        pcInSelect,
  output excPkg::excCause_t excCause
);
  import pipePkg::*;
  import excPkg::*;

  // Decode reads a register that the load in execute has not fetched yet
  logic ldrStallD;
  // Memory or instruction port not ready
  logic memWait;

  // Operand A, memory stage first, then writeback
  // Micro-op sequences take the updated base from memory
  always_comb begin
    if ((match1EM && regWriteM) || ldmStmForwardE) begin
      forwardAE = FwdM;
    end else if (match1EW && regWriteW) begin
      forwardAE = FwdW;
    end else begin
      forwardAE = FwdNone;
    end
  end

  // Operand B, same order without the micro-op override
  always_comb begin
    if (match2EM && regWriteM) begin
      forwardBE = FwdM;
    end else if (match2EW && regWriteW) begin
      forwardBE = FwdW;
    end else begin
      forwardBE = FwdNone;
    end
  end

  // Base register increment for LDM/STM
  assign incrementE = ldmStmForwardE;

  assign ldrStallD = (match1DE | match2DE) & memToRegE;
  assign memWait = dStall | iStall;

  // Hold fetch for load use, PC writes, back-pressure, micro-ops
  // Also hold while a SWI or undefined op is still ahead of writeback
  assign stallF = ldrStallD | pcWrPendingF | memWait | uOpStallD | multStallD
                | swiD | swiE | swiM | undefD | undefE | undefM;
  assign stallD = ldrStallD | memWait | uOpStallD | multStallD | swiE | undefE;
  assign stallUop = ldrStallD | memWait | multStallD;

  // Back-pressure freezes the back end and drops the retiring slot
  assign stallE = memWait;
  assign stallM = memWait;
  assign stallW = memWait;
  assign flushW = memWait;

  // Bubble into execute behind a load or a taken branch
  assign flushE = ldrStallD | branchTakenE | swiM | undefM;
  // Squash wrong-path fetches
  assign flushD = pcWrPendingF | pcSrcW | branchTakenE | iStall
                | swiE | swiM | swiW | undefE | undefM | undefW;

  // Return address saved as the SWI leaves execute
  assign exceptionSavePC = swiE;

  // Exception priority, highest first
  // Return offset comes with the cause
  always_comb begin
    excCause = excNone;
    pcInSelect = PcInPlus8;
    if (prefetchAbort) begin
      excCause = excPrefetchAbort;
    end else if (dataAbort) begin
      excCause = excDataAbort;
      pcInSelect = PcInPlus0;
    end else if (irq) begin
      excCause = excIrq;
    end else if (fiq) begin
      excCause = excFiq;
    end else if (undefInstr) begin
      excCause = excUndef;
      pcInSelect = PcInPlus4;
    end else if (swi) begin
      excCause = excSwi;
      pcInSelect = PcInPlus0;
    end
  end

endmodule

// File: rtl/excPkg.sv
package excPkg;

  // Exception cause, also the index into the vector table
  typedef enum logic [2:0] {
    excNone          = 3'd0,
    excPrefetchAbort = 3'd1,
    excDataAbort     = 3'd2,
    excIrq           = 3'd3,
    excFiq           = 3'd4,
    excUndef         = 3'd5,
    excSwi           = 3'd6
  } excCause_t;

  // Offset removed from the fetch PC for the return address
  // Fetch is two words ahead of execute
  localparam logic [1:0] PcInPlus8 = 2'd0;
  localparam logic [1:0] PcInPlus4 = 2'd1;
  // SWI return is written one cycle late, so no offset
  localparam logic [1:0] PcInPlus0 = 2'd2;

  // Vector addresses in ARM order, indexed by cause
  localparam logic [31:0] vectorAddr [8] = '{
    32'h0000_0000,  // none, unused
    32'h0000_000C,  // prefetch abort
    32'h0000_0010,  // data abort
    32'h0000_0018,  // IRQ
    32'h0000_001C,  // FIQ
    32'h0000_0004,  // undefined
    32'h0000_0008,  // SWI
    32'h0000_0000   // spare code
  };

endpackage

// File: rtl/pipePkg.sv
package pipePkg;

  // Register file index, sixteen architectural registers
  localparam int unsigned RegIdxW = 4;

  // Datapath width of operands and addresses
  localparam int unsigned DataW = 32;

  // Program counter lives in the register file as r15
  localparam logic [RegIdxW-1:0] PcReg = 4'd15;

  // Operand source select for the execute stage
  // Register file value read in decode
  localparam logic [1:0] FwdNone = 2'd0;
  // Result from the writeback stage
  localparam logic [1:0] FwdW = 2'd1;
  // ALU result from the memory stage
  localparam logic [1:0] FwdM = 2'd2;

endpackage
